// ==== common/rename_defs.svh ====
// --------------------------------------------------------------------------
// rename sizing for a two-lane stage
// each LOG_ value is set by hand and must track its count
// --------------------------------------------------------------------------
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// register files
`define AR_COUNT 32
`define PR_COUNT 64
`define LOG_AR_COUNT 5
`define LOG_PR_COUNT 6

// group size
`define RENAME_WIDTH 2

// branch checkpoints, power of two
`define CHECKPOINT_COUNT 4
`define LOG_CHECKPOINT_COUNT 2

`endif

// ==== common/core_types_pkg.sv ====
// --------------------------------------------------------------------------
// register index types for the rename blocks
// --------------------------------------------------------------------------
`default_nettype none

`include "rename_defs.svh"

package core_types_pkg;

    // architectural register index
    typedef logic [`LOG_AR_COUNT-1:0] ar_t;

    // physical register index
    typedef logic [`LOG_PR_COUNT-1:0] pr_t;

    // free-list pointer
    // msb is the wrap bit, so full and empty differ
    typedef logic [`LOG_PR_COUNT:0] fl_ptr_t;

endpackage

`default_nettype wire

// ==== common/checkpoint_pkg.sv ====
// --------------------------------------------------------------------------
// checkpoint id and map snapshot types
// --------------------------------------------------------------------------
`default_nettype none

`include "rename_defs.svh"

package checkpoint_pkg;

    import core_types_pkg::*;

    // slot in the checkpoint store
    typedef logic [`LOG_CHECKPOINT_COUNT-1:0] checkpoint_id_t;

    // whole map, one pr_t per arch reg
    typedef pr_t [`AR_COUNT-1:0] map_snapshot_t;

endpackage

`default_nettype wire

// ==== rename/map_table.sv ====
// --------------------------------------------------------------------------
// reads see the map before this cycle's writes
// higher write port wins; restore overrides all writes
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module map_table
    import core_types_pkg::*;
    import checkpoint_pkg::*;
(
    input  logic                                 CLK,
    input  logic                                 nRST,

    // two sources and the old dest per lane
    input  ar_t [3*`RENAME_WIDTH-1:0]            read_ar,
    output pr_t [3*`RENAME_WIDTH-1:0]            read_pr,

    // one write per lane
    input  logic [`RENAME_WIDTH-1:0]             write_valid,
    input  ar_t  [`RENAME_WIDTH-1:0]             write_ar,
    input  pr_t  [`RENAME_WIDTH-1:0]             write_pr,

    // checkpoint save view
    output map_snapshot_t                        save_map,

    // mispredict restore
    input  logic                                 restore_valid,
    input  map_snapshot_t                        restore_map
);

    // ------------------------------------------------------------------------
    // state

    map_snapshot_t map_q;
    map_snapshot_t map_updated;

    // ------------------------------------------------------------------------
    // lookup and update

    // plain lookups against the current map
    always_comb begin
        for (int rport = 0; rport < 3*`RENAME_WIDTH; rport++) begin
            read_pr[rport] = map_q[read_ar[rport]];
        end
    end

    // apply writes low to high
    // same ar in two lanes leaves the younger lane's value
    always_comb begin
        map_updated = map_q;
        for (int wport = 0; wport < `RENAME_WIDTH; wport++) begin
            if (write_valid[wport]) begin
                map_updated[write_ar[wport]] = write_pr[wport];
            end
        end
    end

    // a branch checkpoint includes its own group
    assign save_map = map_updated;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // identity map
            for (int ar = 0; ar < `AR_COUNT; ar++) begin
                map_q[ar] <= pr_t'(ar);
            end
        end else if (restore_valid) begin
            map_q <= restore_map;
        end else begin
            map_q <= map_updated;
        end
    end

endmodule

`default_nettype wire

// ==== rename/free_list.sv ====
// --------------------------------------------------------------------------
// caller must not pop more than free_count or push past 64 entries
// restore moves only the head; frees in that cycle still land
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module free_list
    import core_types_pkg::*;
(
    input  logic                            CLK,
    input  logic                            nRST,

    // allocation, 0 to 2 pops
    input  logic [1:0]                      alloc_count,
    output pr_t [`RENAME_WIDTH-1:0]         alloc_pr,
    output logic [`LOG_PR_COUNT:0]          free_count,

    // commit frees, pushed in port order
    input  logic [1:0]                      free_valid,
    input  pr_t  [1:0]                      free_pr,

    // head for a checkpoint taken this cycle
    output fl_ptr_t                         head_after_alloc,

    // mispredict restore
    input  logic                            restore_valid,
    input  fl_ptr_t                         restore_head
);

    // ------------------------------------------------------------------------
    // queue and pointers

    pr_t [`PR_COUNT-1:0] queue;
    fl_ptr_t             head;
    fl_ptr_t             tail;

    logic [`LOG_PR_COUNT-1:0] pop_slot  [`RENAME_WIDTH];
    logic [`LOG_PR_COUNT-1:0] push_slot [2];

    // ------------------------------------------------------------------------
    // pop side

    // next two free regs, index drops the wrap bit
    assign pop_slot[0] = head[`LOG_PR_COUNT-1:0];
    assign pop_slot[1] = head[`LOG_PR_COUNT-1:0] + 1'b1;
    assign alloc_pr[0] = queue[pop_slot[0]];
    assign alloc_pr[1] = queue[pop_slot[1]];

    assign head_after_alloc = head + fl_ptr_t'(alloc_count);

    // wrap bits make this exact from 0 to 64
    assign free_count = tail - head;

    // ------------------------------------------------------------------------
    // push side

    // port 1 goes behind port 0 when both push
    assign push_slot[0] = tail[`LOG_PR_COUNT-1:0];
    assign push_slot[1] = tail[`LOG_PR_COUNT-1:0] + `LOG_PR_COUNT'(free_valid[0]);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // slots 0..31 hold pr 32..63
            // upper slots get don't-care values
            for (int slot = 0; slot < `PR_COUNT; slot++) begin
                queue[slot] <= pr_t'(slot + `AR_COUNT);
            end
            head <= '0;
            tail <= fl_ptr_t'(`PR_COUNT - `AR_COUNT);
        end else begin
            for (int port = 0; port < 2; port++) begin
                if (free_valid[port]) begin
                    queue[push_slot[port]] <= free_pr[port];
                end
            end
            tail <= tail + fl_ptr_t'(free_valid[0]) + fl_ptr_t'(free_valid[1]);
            // regs popped after the checkpoint become free again
            if (restore_valid) begin
                head <= restore_head;
            end else begin
                head <= head_after_alloc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rename/checkpoint_array.sv ====
// --------------------------------------------------------------------------
// no save while full and no release while empty
// restore_id must name a live checkpoint
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module checkpoint_array
    import checkpoint_pkg::*;
#(
    parameter type entry_t = logic
) (
    input  logic            CLK,
    input  logic            nRST,

    // allocate at the alloc pointer
    input  logic            save_valid,
    input  entry_t          save_entry,
    output checkpoint_id_t  save_id,
    output logic            full,

    // oldest goes first
    input  logic            release_valid,

    // read by id, drop it and all younger
    input  logic            restore_valid,
    input  checkpoint_id_t  restore_id,
    output entry_t          restore_entry
);

    // pointer with wrap bit
    typedef logic [`LOG_CHECKPOINT_COUNT:0] ptr_t;

    entry_t         slots [`CHECKPOINT_COUNT];
    ptr_t           alloc_ptr;
    ptr_t           release_ptr;
    checkpoint_id_t restore_age;
    ptr_t           restore_alloc;

    assign save_id       = alloc_ptr[`LOG_CHECKPOINT_COUNT-1:0];
    assign restore_entry = slots[restore_id];

    // same slot index, other lap
    assign full = (alloc_ptr[`LOG_CHECKPOINT_COUNT] != release_ptr[`LOG_CHECKPOINT_COUNT])
               && (save_id == release_ptr[`LOG_CHECKPOINT_COUNT-1:0]);

    // distance from oldest picks the right lap for the new alloc pointer
    assign restore_age   = restore_id - release_ptr[`LOG_CHECKPOINT_COUNT-1:0];
    assign restore_alloc = release_ptr + ptr_t'(restore_age) + 1'b1;

    always_ff @(posedge CLK) begin
        if (save_valid) begin
            slots[save_id] <= save_entry;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            alloc_ptr   <= '0;
            release_ptr <= '0;
        end else begin
            if (restore_valid) begin
                alloc_ptr <= restore_alloc;
            end else if (save_valid) begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end
            if (release_valid) begin
                release_ptr <= release_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rename/rename_unit.sv ====
// --------------------------------------------------------------------------
// lane outputs are combinational and valid only when valid and ready are high
// ready asks for two free regs even when the group needs fewer
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module rename_unit
    import core_types_pkg::*;
    import checkpoint_pkg::*;
(
    input  logic                        CLK,
    input  logic                        nRST,

    // front end handshake
    input  logic                        rename_valid,
    output logic                        rename_ready,
    input  logic [`RENAME_WIDTH-1:0]    dest_valid,
    input  ar_t  [`RENAME_WIDTH-1:0]    dest_ar,
    input  ar_t  [`RENAME_WIDTH-1:0]    src1_ar,
    input  ar_t  [`RENAME_WIDTH-1:0]    src2_ar,
    input  logic                        branch_ckpt,

    // renamed lanes
    output pr_t  [`RENAME_WIDTH-1:0]    src1_pr,
    output pr_t  [`RENAME_WIDTH-1:0]    src2_pr,
    output pr_t  [`RENAME_WIDTH-1:0]    dest_pr,
    output pr_t  [`RENAME_WIDTH-1:0]    old_dest_pr,
    output checkpoint_id_t              ckpt_id,

    // commit frees, never stalled
    input  logic [1:0]                  commit_free_valid,
    input  pr_t  [1:0]                  commit_free_pr,

    // mispredict and retire of checkpoints
    input  logic                        restore_valid,
    input  checkpoint_id_t              restore_id,
    input  logic                        release_valid
);

    // ------------------------------------------------------------------------
    // internal signals

    logic                           transfer;
    logic                           save_valid;
    logic [1:0]                     alloc_count;
    ar_t  [3*`RENAME_WIDTH-1:0]     read_ar;
    pr_t  [3*`RENAME_WIDTH-1:0]     read_pr;
    logic [`RENAME_WIDTH-1:0]       write_valid;
    pr_t  [`RENAME_WIDTH-1:0]       alloc_pr;
    logic [`LOG_PR_COUNT:0]         free_count;
    fl_ptr_t                        head_after_alloc;
    fl_ptr_t                        restore_head;
    map_snapshot_t                  save_map;
    map_snapshot_t                  restore_map;
    logic                           map_ckpt_full;
    logic                           head_ckpt_full;
    logic                           lane1_src1_hit;
    logic                           lane1_src2_hit;
    logic                           lane1_dest_hit;

    // ------------------------------------------------------------------------
    // handshake

    assign rename_ready = (free_count >= `RENAME_WIDTH)
                       && (!branch_ckpt || !(map_ckpt_full || head_ckpt_full))
                       && !restore_valid;
    assign transfer     = rename_valid && rename_ready;
    assign save_valid   = transfer && branch_ckpt;

    // ------------------------------------------------------------------------
    // lookup, allocation and bypass

    // read port order per lane is src1, src2, dest
    always_comb begin
        for (int lane = 0; lane < `RENAME_WIDTH; lane++) begin
            read_ar[3*lane]     = src1_ar[lane];
            read_ar[3*lane + 1] = src2_ar[lane];
            read_ar[3*lane + 2] = dest_ar[lane];
        end
    end

    // lane 1 takes the first free reg if lane 0 has no dest
    assign dest_pr[0]  = alloc_pr[0];
    assign dest_pr[1]  = dest_valid[0] ? alloc_pr[1] : alloc_pr[0];
    assign alloc_count = transfer ? (2'(dest_valid[0]) + 2'(dest_valid[1])) : 2'd0;
    assign write_valid = transfer ? dest_valid : '0;

    // lane 0 dest seen by lane 1 in the same group
    assign lane1_src1_hit = dest_valid[0] && (dest_ar[0] == src1_ar[1]);
    assign lane1_src2_hit = dest_valid[0] && (dest_ar[0] == src2_ar[1]);
    assign lane1_dest_hit = dest_valid[0] && (dest_ar[0] == dest_ar[1]);

    assign src1_pr[0]     = read_pr[0];
    assign src2_pr[0]     = read_pr[1];
    assign old_dest_pr[0] = read_pr[2];
    assign src1_pr[1]     = lane1_src1_hit ? dest_pr[0] : read_pr[3];
    assign src2_pr[1]     = lane1_src2_hit ? dest_pr[0] : read_pr[4];
    // lane 1 frees lane 0's reg when both write the same ar
    assign old_dest_pr[1] = lane1_dest_hit ? dest_pr[0] : read_pr[5];

    // ------------------------------------------------------------------------
    // blocks

    map_table u_map_table (
        .CLK           (CLK),
        .nRST          (nRST),
        .read_ar       (read_ar),
        .read_pr       (read_pr),
        .write_valid   (write_valid),
        .write_ar      (dest_ar),
        .write_pr      (dest_pr),
        .save_map      (save_map),
        .restore_valid (restore_valid),
        .restore_map   (restore_map)
    );

    free_list u_free_list (
        .CLK              (CLK),
        .nRST             (nRST),
        .alloc_count      (alloc_count),
        .alloc_pr         (alloc_pr),
        .free_count       (free_count),
        .free_valid       (commit_free_valid),
        .free_pr          (commit_free_pr),
        .head_after_alloc (head_after_alloc),
        .restore_valid    (restore_valid),
        .restore_head     (restore_head)
    );

    // map snapshots, taken with the branch group's writes applied
    checkpoint_array #(
        .entry_t (map_snapshot_t)
    ) u_map_ckpt (
        .CLK           (CLK),
        .nRST          (nRST),
        .save_valid    (save_valid),
        .save_entry    (save_map),
        .save_id       (ckpt_id),
        .full          (map_ckpt_full),
        .release_valid (release_valid),
        .restore_valid (restore_valid),
        .restore_id    (restore_id),
        .restore_entry (restore_map)
    );

    // free-list heads, kept in step with the map store
    // so its save_id always equals ckpt_id
    checkpoint_array #(
        .entry_t (fl_ptr_t)
    ) u_head_ckpt (
        .CLK           (CLK),
        .nRST          (nRST),
        .save_valid    (save_valid),
        .save_entry    (head_after_alloc),
        .save_id       (),
        .full          (head_ckpt_full),
        .release_valid (release_valid),
        .restore_valid (restore_valid),
        .restore_id    (restore_id),
        .restore_entry (restore_head)
    );

endmodule

`default_nettype wire

// ==== verif/rename_asserts.sv ====
// --------------------------------------------------------------------------
// bound into rename_unit, sees its internal transfer and free count
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module rename_asserts
    import core_types_pkg::*;
    import checkpoint_pkg::*;
(
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        rename_ready,
    input  logic                        restore_valid,
    input  checkpoint_id_t              restore_id,
    input  logic [`LOG_PR_COUNT:0]      free_count,
    input  checkpoint_id_t              ckpt_id,
    input  logic                        transfer,
    input  logic [`RENAME_WIDTH-1:0]    dest_valid,
    input  pr_t  [`RENAME_WIDTH-1:0]    dest_pr
);

    // count of failed assertions
    int failures = 0;

    // stalled cycle pops no regs and takes no checkpoint
    // only a restore may move the checkpoint slot
    no_alloc_when_stalled: assert property (@(posedge CLK) disable iff (!nRST)
        !rename_ready |=> (free_count >= $past(free_count))
            && ($past(restore_valid) || (ckpt_id == $past(ckpt_id))))
        else begin
            $error("registers popped or checkpoint saved while ready is low");
            failures++;
        end

    // two dests in one group never share a reg
    distinct_dest: assert property (@(posedge CLK) disable iff (!nRST)
        (transfer && dest_valid[0] && dest_valid[1]) |-> (dest_pr[0] != dest_pr[1]))
        else begin
            $error("both lanes got the same physical register");
            failures++;
        end

    // restore reopens the slot just after the named checkpoint
    restore_reopens_slot: assert property (@(posedge CLK) disable iff (!nRST)
        restore_valid |=> (ckpt_id == checkpoint_id_t'($past(restore_id) + 1'b1)))
        else begin
            $error("checkpoint slot after a restore does not follow restore_id");
            failures++;
        end

endmodule

`default_nettype wire

// ==== verif/rename_tb.sv ====
// --------------------------------------------------------------------------
// self-checking testbench for the two-lane rename stage
// commit frees only return regs whose groups can no longer be rolled back
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module rename_tb
    import core_types_pkg::*;
    import checkpoint_pkg::*;
();

    // about 400 cycles of tests, with wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_GROUPS  = 40;

    // per lane: src1, src2, dest, old dest
    typedef pr_t [7:0] lanes_t;

    typedef struct packed {
        checkpoint_id_t id;
        map_snapshot_t  map;
        int             pops;
        int             retires;
    } ckpt_rec_t;

    logic                 CLK = 1'b0;
    logic                 nRST;
    logic                 rename_valid;
    logic                 rename_ready;
    logic [1:0]           dest_valid;
    ar_t  [1:0]           dest_ar;
    ar_t  [1:0]           src1_ar;
    ar_t  [1:0]           src2_ar;
    logic                 branch_ckpt;
    pr_t  [1:0]           src1_pr;
    pr_t  [1:0]           src2_pr;
    pr_t  [1:0]           dest_pr;
    pr_t  [1:0]           old_dest_pr;
    checkpoint_id_t       ckpt_id;
    logic [1:0]           commit_free_valid;
    pr_t  [1:0]           commit_free_pr;
    logic                 restore_valid;
    checkpoint_id_t       restore_id;
    logic                 release_valid;

    // ------------------------------------------------------------------------
    // reference model state

    map_snapshot_t  ref_map;
    pr_t            free_q [$];
    // every pop in order, so a restore can hand regs back
    pr_t            pop_hist [$];
    // displaced regs waiting for commit
    pr_t            retire_q [$];
    ckpt_rec_t      ckpt_q [$];
    checkpoint_id_t next_id;
    ckpt_rec_t      new_rec;
    lanes_t         expected;
    logic           exp_ready;

    string          test_name;
    int             checks;
    int             errors;
    int             test_checks;
    int             test_errors;
    int             cycles;
    logic [31:0]    rand_state;

    always #2 CLK = ~CLK;

    rename_unit u_rename_unit (
        .CLK               (CLK),
        .nRST              (nRST),
        .rename_valid      (rename_valid),
        .rename_ready      (rename_ready),
        .dest_valid        (dest_valid),
        .dest_ar           (dest_ar),
        .src1_ar           (src1_ar),
        .src2_ar           (src2_ar),
        .branch_ckpt       (branch_ckpt),
        .src1_pr           (src1_pr),
        .src2_pr           (src2_pr),
        .dest_pr           (dest_pr),
        .old_dest_pr       (old_dest_pr),
        .ckpt_id           (ckpt_id),
        .commit_free_valid (commit_free_valid),
        .commit_free_pr    (commit_free_pr),
        .restore_valid     (restore_valid),
        .restore_id        (restore_id),
        .release_valid     (release_valid)
    );

    bind rename_unit rename_asserts u_rename_asserts (
        .CLK           (CLK),
        .nRST          (nRST),
        .rename_ready  (rename_ready),
        .restore_valid (restore_valid),
        .restore_id    (restore_id),
        .free_count    (free_count),
        .ckpt_id       (ckpt_id),
        .transfer      (transfer),
        .dest_valid    (dest_valid),
        .dest_pr       (dest_pr)
    );

    // ------------------------------------------------------------------------
    // helpers

    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    task automatic check_value(input string what, input int exp_val, input int act_val);
        checks++;
        test_checks++;
        if (exp_val != act_val) begin
            errors++;
            test_errors++;
            $display("mismatch %s %s: expected %0d actual %0d",
                     test_name, what, exp_val, act_val);
        end
    endtask

    // lookup, then lane 0 dest seen by lane 1, first free reg to first dest
    function automatic lanes_t predict_group();
        lanes_t lanes;
        pr_t    new0;
        pr_t    new1;
        new0     = free_q[0];
        new1     = dest_valid[0] ? free_q[1] : free_q[0];
        lanes[0] = ref_map[src1_ar[0]];
        lanes[1] = ref_map[src2_ar[0]];
        lanes[2] = new0;
        lanes[3] = ref_map[dest_ar[0]];
        lanes[4] = (dest_valid[0] && dest_ar[0] == src1_ar[1]) ? new0 : ref_map[src1_ar[1]];
        lanes[5] = (dest_valid[0] && dest_ar[0] == src2_ar[1]) ? new0 : ref_map[src2_ar[1]];
        lanes[6] = new1;
        lanes[7] = (dest_valid[0] && dest_ar[0] == dest_ar[1]) ? new0 : ref_map[dest_ar[1]];
        return lanes;
    endfunction

    task automatic apply_group();
        for (int lane = 0; lane < 2; lane++) begin
            check_value($sformatf("lane%0d src1", lane),
                        int'(expected[4*lane]), int'(src1_pr[lane]));
            check_value($sformatf("lane%0d src2", lane),
                        int'(expected[4*lane + 1]), int'(src2_pr[lane]));
            if (dest_valid[lane]) begin
                check_value($sformatf("lane%0d dest", lane),
                            int'(expected[4*lane + 2]), int'(dest_pr[lane]));
                check_value($sformatf("lane%0d old dest", lane),
                            int'(expected[4*lane + 3]), int'(old_dest_pr[lane]));
                // lane order, so lane 1 wins on the same ar
                ref_map[dest_ar[lane]] = expected[4*lane + 2];
                retire_q.push_back(expected[4*lane + 3]);
                pop_hist.push_back(free_q.pop_front());
            end
        end
        if (branch_ckpt) begin
            check_value("ckpt id", int'(next_id), int'(ckpt_id));
            new_rec.id      = next_id;
            new_rec.map     = ref_map;
            new_rec.pops    = pop_hist.size();
            new_rec.retires = retire_q.size();
            ckpt_q.push_back(new_rec);
            next_id = next_id + 1'b1;
        end
    endtask

    // the named checkpoint stays live, younger ones go
    function automatic void restore_model(input checkpoint_id_t id);
        int hit;
        hit = -1;
        foreach (ckpt_q[i]) begin
            if (ckpt_q[i].id == id) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            errors++;
            test_errors++;
            $display("restore names checkpoint %0d, which is not live", id);
        end else begin
            ref_map = ckpt_q[hit].map;
            // popped regs go back to the head in their old order
            while (pop_hist.size() > ckpt_q[hit].pops) begin
                free_q.push_front(pop_hist.pop_back());
            end
            while (retire_q.size() > ckpt_q[hit].retires) begin
                void'(retire_q.pop_back());
            end
            while (ckpt_q.size() > hit + 1) begin
                void'(ckpt_q.pop_back());
            end
            next_id = id + 1'b1;
        end
    endfunction

    // ------------------------------------------------------------------------
    // compare and model update

    always @(posedge CLK) begin
        if (nRST) begin
            if (rename_valid) begin
                exp_ready = (free_q.size() >= `RENAME_WIDTH)
                         && (!branch_ckpt || ckpt_q.size() < `CHECKPOINT_COUNT)
                         && !restore_valid;
                check_value("ready", int'(exp_ready), int'(rename_ready));
            end
            if (rename_valid && rename_ready) begin
                expected = predict_group();
                apply_group();
            end
            if (restore_valid) begin
                restore_model(restore_id);
            end
            for (int port = 0; port < 2; port++) begin
                if (commit_free_valid[port]) begin
                    free_q.push_back(commit_free_pr[port]);
                end
            end
            if (release_valid) begin
                void'(ckpt_q.pop_front());
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus tasks

    task automatic drive_group(input logic [1:0] dv, input ar_t d0, input ar_t d1,
                               input ar_t a0, input ar_t b0, input ar_t a1, input ar_t b1,
                               input logic br);
        @(negedge CLK);
        rename_valid = 1'b1;
        dest_valid   = dv;
        dest_ar[0]   = d0;
        dest_ar[1]   = d1;
        src1_ar[0]   = a0;
        src2_ar[0]   = b0;
        src1_ar[1]   = a1;
        src2_ar[1]   = b1;
        branch_ckpt  = br;
    endtask

    // small ar range so bypass and same-dest cases show up often
    task automatic drive_random(input logic br, input logic all_dest);
        logic [1:0] dv;
        ar_t        pick [6];
        dv = all_dest ? 2'b11 : 2'(next_rand());
        for (int i = 0; i < 6; i++) begin
            pick[i] = ar_t'(next_rand() % 8);
        end
        drive_group(dv, pick[0], pick[1], pick[2], pick[3], pick[4], pick[5], br);
    endtask

    task automatic wait_transfer();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(posedge CLK);
            done = rename_ready;
        end
        @(negedge CLK);
        rename_valid = 1'b0;
        branch_ckpt  = 1'b0;
    endtask

    task automatic hold_group(input int count);
        repeat (count) @(posedge CLK);
        @(negedge CLK);
        rename_valid = 1'b0;
        branch_ckpt  = 1'b0;
    endtask

    task automatic commit_frees(input int count);
        @(negedge CLK);
        for (int port = 0; port < 2; port++) begin
            if (port < count && retire_q.size() > 0) begin
                commit_free_valid[port] = 1'b1;
                commit_free_pr[port]    = retire_q.pop_front();
            end
        end
        @(negedge CLK);
        commit_free_valid = '0;
    endtask

    task automatic drain_retired();
        while (retire_q.size() > 0) begin
            commit_frees(2);
        end
    endtask

    task automatic pulse_restore(input checkpoint_id_t id);
        @(negedge CLK);
        restore_valid = 1'b1;
        restore_id    = id;
        @(negedge CLK);
        restore_valid = 1'b0;
    endtask

    task automatic pulse_release();
        @(negedge CLK);
        release_valid = 1'b1;
        @(negedge CLK);
        release_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    // ------------------------------------------------------------------------
    // test sequence

    initial begin
        checkpoint_id_t saved_id;
        pr_t            after_ckpt;
        rand_state        = 32'd74164;
        checks            = 0;
        errors            = 0;
        cycles            = 0;
        nRST              = 1'b0;
        rename_valid      = 1'b0;
        dest_valid        = '0;
        dest_ar           = '0;
        src1_ar           = '0;
        src2_ar           = '0;
        branch_ckpt       = 1'b0;
        commit_free_valid = '0;
        commit_free_pr    = '0;
        restore_valid     = 1'b0;
        restore_id        = '0;
        release_valid     = 1'b0;
        next_id           = '0;
        // identity map, free regs 32..63 in order
        for (int ar = 0; ar < `AR_COUNT; ar++) begin
            ref_map[ar] = pr_t'(ar);
        end
        for (int pr = `AR_COUNT; pr < `PR_COUNT; pr++) begin
            free_q.push_back(pr_t'(pr));
        end
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        start_test("reset state");
        drive_group(2'b11, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 1'b0);
        wait_transfer();
        // lane 1 src1 reads lane 0's new reg
        drive_group(2'b11, 5'd7, 5'd8, 5'd1, 5'd2, 5'd7, 5'd9, 1'b0);
        wait_transfer();
        end_test();

        start_test("random groups");
        repeat (RANDOM_GROUPS) begin
            drive_random(1'b0, 1'b0);
            wait_transfer();
            commit_frees(2);
        end
        drain_retired();
        end_test();

        start_test("free list empty");
        repeat ((`PR_COUNT - `AR_COUNT) / 2) begin
            drive_random(1'b0, 1'b1);
            wait_transfer();
        end
        drive_random(1'b0, 1'b1);
        hold_group(3);
        commit_frees(2);
        drive_random(1'b0, 1'b1);
        wait_transfer();
        drain_retired();
        end_test();

        start_test("checkpoint restore");
        drive_random(1'b1, 1'b0);
        wait_transfer();
        saved_id   = ckpt_q[ckpt_q.size() - 1].id;
        after_ckpt = free_q[0];
        repeat (3) begin
            drive_random(1'b0, 1'b1);
            wait_transfer();
        end
        pulse_restore(saved_id);
        drive_random(1'b0, 1'b1);
        #1;
        check_value("first alloc after restore", int'(after_ckpt), int'(dest_pr[0]));
        wait_transfer();
        pulse_release();
        drain_retired();
        end_test();

        start_test("checkpoint full");
        repeat (`CHECKPOINT_COUNT) begin
            drive_random(1'b1, 1'b0);
            wait_transfer();
        end
        // branch group stalls, plain group still goes
        drive_random(1'b1, 1'b0);
        hold_group(3);
        drive_random(1'b0, 1'b0);
        wait_transfer();
        pulse_release();
        drive_random(1'b1, 1'b0);
        wait_transfer();
        end_test();

        $display("all tests: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, u_rename_unit.u_rename_asserts.failures);
        if (errors == 0 && u_rename_unit.u_rename_asserts.failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/core_types_pkg.sv
common/checkpoint_pkg.sv
rename/map_table.sv
rename/free_list.sv
rename/checkpoint_array.sv
rename/rename_unit.sv
verif/rename_asserts.sv
verif/rename_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rename testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal -f compile.f \
    --top-module rename_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vrename_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    exit 0
fi
exit 1
